/* include/pbch_settings.svh */
`ifndef PBCH_SETTINGS_SVH
`define PBCH_SETTINGS_SVH

// width of one I or Q component of a subcarrier sample
`define PBCH_IQ_W 16

// subcarriers per OFDM symbol and distance between DMRS pilots
`define PBCH_FFT_LEN 256
`define PBCH_PILOT_SPACING 4

// number of candidate SSB indices and QPSK pairs per DMRS sequence
`define PBCH_NUM_IBAR 8
`define PBCH_DMRS_LEN 144

// Gold sequence generator, length of both LFSRs and bits discarded after load
`define PBCH_LFSR_N 31
`define PBCH_GOLD_NC 1600

// largest physical cell ID
`define PBCH_MAX_CELL_ID 1007

`endif

/* src/pbch_pkg.sv */
`default_nettype none

`include "pbch_settings.svh"

package pbch_pkg;

    // largest correlation, two bits per pilot over one symbol
    localparam int CORR_MAX = 2 * `PBCH_FFT_LEN / `PBCH_PILOT_SPACING;

    typedef logic [$clog2(`PBCH_MAX_CELL_ID + 1)-1:0] cell_id_t;
    typedef logic [$clog2(`PBCH_NUM_IBAR)-1:0] ibar_t;
    // bit 1 holds the even Gold bit, bit 0 the odd one
    typedef logic [1:0] dmrs_pair_t;
    typedef logic [$clog2(`PBCH_DMRS_LEN)-1:0] dmrs_idx_t;
    typedef dmrs_pair_t [`PBCH_NUM_IBAR-1:0] dmrs_row_t;
    typedef logic signed [$clog2(CORR_MAX)+1:0] corr_t;
    typedef logic [$clog2(CORR_MAX):0] corr_mag_t;

    typedef struct packed {
        logic signed [`PBCH_IQ_W-1:0] im;
        logic signed [`PBCH_IQ_W-1:0] re;
    } iq_sample_t;

    typedef struct packed {
        logic       valid;
        dmrs_idx_t  idx;
        dmrs_pair_t pair;
    } pilot_strobe_t;

    // hard QPSK decision, a negative component gives a one
    function automatic dmrs_pair_t qpsk_demod(input iq_sample_t s);
        return {s.re[`PBCH_IQ_W-1], s.im[`PBCH_IQ_W-1]};
    endfunction

endpackage

`default_nettype wire

/* src/gold_seq_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module gold_seq_gen import pbch_pkg::*; (
    input  wire                       clk_i,
    input  wire                       reset_ni,
    input  wire cell_id_t             n_id_i,
    input  wire                       load_i,
    input  wire                       step_i,
    output logic [`PBCH_NUM_IBAR-1:0] gold_bits_o
);

    typedef logic [`PBCH_LFSR_N-1:0] lfsr_t;

    // bit k of each register holds x(n+k), so bit 0 is the current output
    lfsr_t    x1_q;
    lfsr_t    x2_q [`PBCH_NUM_IBAR];
    cell_id_t n_id_q;

    function automatic lfsr_t c_init(input int unsigned ibar, input cell_id_t n_id);
        lfsr_t ibar_p1;
        lfsr_t group_p1;
        ibar_p1 = lfsr_t'(ibar + 1);
        group_p1 = lfsr_t'(n_id >> 2) + 1'b1;
        return ((ibar_p1 * group_p1) << 11) + (ibar_p1 << 6) + lfsr_t'(n_id[1:0]);
    endfunction

    // the load comes one cycle after the accepted ID, so one stage aligns it
    always_ff @(posedge clk_i) begin
        n_id_q <= n_id_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q <= '0;
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                x2_q[i] <= '0;
            end
        end else if (load_i) begin
            x1_q <= lfsr_t'(1);
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                x2_q[i] <= c_init(i, n_id_q);
            end
        end else if (step_i) begin
            // x1 feedback from taps 3 and 0, x2 from taps 3 down to 0
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[`PBCH_LFSR_N-1:1]};
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                x2_q[i] <= {x2_q[i][3] ^ x2_q[i][2] ^ x2_q[i][1] ^ x2_q[i][0],
                            x2_q[i][`PBCH_LFSR_N-1:1]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            gold_bits_o[i] = x1_q[0] ^ x2_q[i][0];
        end
    end

endmodule

`default_nettype wire

/* src/dmrs_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module dmrs_store import pbch_pkg::*; (
    input  wire                       clk_i,
    input  wire                       we_i,
    input  wire dmrs_idx_t            idx_i,
    input  wire                       phase_i,
    input  wire [`PBCH_NUM_IBAR-1:0]  gold_bits_i,
    input  wire dmrs_idx_t            rd_idx_i,
    output dmrs_row_t                 row_o
);

    // one row holds the pair at this index for all candidates
    dmrs_row_t mem [`PBCH_DMRS_LEN];

    // the Gold bits arrive serially, even bit first
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                if (!phase_i) begin
                    mem[idx_i][i][1] <= gold_bits_i[i];
                end else begin
                    mem[idx_i][i][0] <= gold_bits_i[i];
                end
            end
        end
    end

    // asynchronous read lets the correlator compare in the pilot's own cycle
    assign row_o = mem[rd_idx_i];

endmodule

`default_nettype wire

/* src/dmrs_correlator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module dmrs_correlator import pbch_pkg::*; (
    input  wire                clk_i,
    input  wire                reset_ni,
    input  wire pilot_strobe_t pilot_i,
    input  wire dmrs_row_t     row_i,
    input  wire                clear_i,
    input  wire                decide_i,
    output ibar_t              ibar_o,
    output corr_mag_t          corr_peak_o,
    output logic               ibar_valid_o
);

    corr_t      acc_q [`PBCH_NUM_IBAR];
    corr_t      acc_rot_q [`PBCH_NUM_IBAR];
    corr_t      delta [`PBCH_NUM_IBAR];
    corr_t      delta_rot [`PBCH_NUM_IBAR];
    corr_mag_t  mag_q [`PBCH_NUM_IBAR];
    dmrs_pair_t pair_rot;
    logic       decide_q;
    ibar_t      best_idx;
    corr_mag_t  best_mag;

    // +1 per matching bit and -1 per differing bit
    function automatic corr_t pair_score(input dmrs_pair_t ref_pair, input dmrs_pair_t rx_pair);
        dmrs_pair_t diff;
        diff = ref_pair ^ rx_pair;
        case (diff)
            2'b00:   return corr_t'(2);
            2'b11:   return corr_t'(-2);
            default: return corr_t'(0);
        endcase
    endfunction

    function automatic corr_mag_t corr_abs(input corr_t value);
        corr_t pos;
        pos = value[$bits(corr_t)-1] ? -value : value;
        return corr_mag_t'(pos);
    endfunction

    always_comb begin
        // received pilot turned by 90 degrees, catches a quarter-turn phase offset
        pair_rot = {~pilot_i.pair[0], pilot_i.pair[1]};
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            delta[i] = pilot_i.valid ? pair_score(row_i[i], pilot_i.pair) : '0;
            delta_rot[i] = pilot_i.valid ? pair_score(row_i[i], pair_rot) : '0;
        end
    end

    // clear and the first pilot of a symbol can fall in the same cycle
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            acc_q[i] <= (clear_i ? corr_t'(0) : acc_q[i]) + delta[i];
            acc_rot_q[i] <= (clear_i ? corr_t'(0) : acc_rot_q[i]) + delta_rot[i];
        end
    end

    // first decision stage keeps the better of the two magnitudes per candidate
    always_ff @(posedge clk_i) begin
        if (decide_i) begin
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                if (corr_abs(acc_rot_q[i]) > corr_abs(acc_q[i])) begin
                    mag_q[i] <= corr_abs(acc_rot_q[i]);
                end else begin
                    mag_q[i] <= corr_abs(acc_q[i]);
                end
            end
        end
    end

    // only a strictly larger magnitude wins, so ties go to the lowest i-bar
    always_comb begin
        best_idx = '0;
        best_mag = mag_q[0];
        for (int i = 1; i < `PBCH_NUM_IBAR; i++) begin
            if (mag_q[i] > best_mag) begin
                best_idx = ibar_t'(i);
                best_mag = mag_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            decide_q <= 1'b0;
            ibar_o <= '0;
            corr_peak_o <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            decide_q <= decide_i;
            ibar_valid_o <= decide_q;
            if (decide_q) begin
                ibar_o <= best_idx;
                corr_peak_o <= best_mag;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pbch_dmrs_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module pbch_dmrs_ctrl import pbch_pkg::*; (
    input  wire             clk_i,
    input  wire             reset_ni,
    input  wire cell_id_t   n_id_i,
    input  wire             n_id_valid_i,
    input  wire iq_sample_t sample_i,
    input  wire             sample_valid_i,
    input  wire             pbch_start_i,
    output logic            gold_load_o,
    output logic            gold_step_o,
    output logic            store_we_o,
    output dmrs_idx_t       store_idx_o,
    output logic            store_phase_o,
    output pilot_strobe_t   pilot_o,
    output logic            corr_clear_o,
    output logic            corr_decide_o,
    output logic            dmrs_ready_o
);

    localparam int GEN_CNT_W = $clog2(`PBCH_GOLD_NC);
    localparam int SC_CNT_W = $clog2(`PBCH_FFT_LEN);
    localparam int OFS_W = $clog2(`PBCH_PILOT_SPACING);
    localparam logic [GEN_CNT_W-1:0] SKIP_LAST = GEN_CNT_W'(`PBCH_GOLD_NC - 1);
    localparam logic [GEN_CNT_W-1:0] STORE_LAST = GEN_CNT_W'(2 * `PBCH_DMRS_LEN - 1);
    localparam logic [SC_CNT_W-1:0] SC_LAST = SC_CNT_W'(`PBCH_FFT_LEN - 1);

    typedef enum logic [2:0] {G_IDLE, G_LOAD, G_SKIP, G_STORE, G_DONE} gen_state_e;
    typedef enum logic [1:0] {D_IDLE, D_SYMBOL, D_DECIDE} det_state_e;

    gen_state_e           gen_state_q;
    det_state_e           det_state_q;
    logic [GEN_CNT_W-1:0] gen_cnt_q;
    logic [OFS_W-1:0]     offset_q;
    logic [SC_CNT_W-1:0]  sc_cnt_q;
    dmrs_idx_t            pilot_cnt_q;
    logic                 id_accept;
    logic                 start_ok;
    logic                 sample_take;
    logic                 is_pilot;
    logic [SC_CNT_W-1:0]  sc_cur;
    dmrs_idx_t            pilot_cur;

    always_comb begin
        // a new cell ID is taken only while no generation is running
        id_accept = n_id_valid_i && (gen_state_q == G_IDLE || gen_state_q == G_DONE);
        start_ok = pbch_start_i && dmrs_ready_o && det_state_q == D_IDLE && !id_accept;
        sample_take = sample_valid_i && (start_ok || det_state_q == D_SYMBOL);

        // the start sample itself counts as subcarrier 0
        sc_cur = (det_state_q == D_SYMBOL) ? sc_cnt_q : '0;
        pilot_cur = (det_state_q == D_SYMBOL) ? pilot_cnt_q : '0;
        is_pilot = sc_cur[OFS_W-1:0] == offset_q;

        pilot_o.valid = sample_take && is_pilot;
        pilot_o.idx = pilot_cur;
        pilot_o.pair = qpsk_demod(sample_i);
        corr_clear_o = start_ok;
        corr_decide_o = det_state_q == D_DECIDE;

        gold_load_o = gen_state_q == G_LOAD;
        gold_step_o = gen_state_q == G_SKIP || gen_state_q == G_STORE;
        store_we_o = gen_state_q == G_STORE;
        // two steps per stored pair, the low count bit selects the half
        store_idx_o = dmrs_idx_t'(gen_cnt_q >> 1);
        store_phase_o = gen_cnt_q[0];
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            gen_state_q <= G_IDLE;
            gen_cnt_q <= '0;
            offset_q <= '0;
            dmrs_ready_o <= 1'b0;
        end else begin
            case (gen_state_q)
                G_LOAD: begin
                    gen_cnt_q <= '0;
                    gen_state_q <= G_SKIP;
                end
                G_SKIP: begin
                    if (gen_cnt_q == SKIP_LAST) begin
                        gen_cnt_q <= '0;
                        gen_state_q <= G_STORE;
                    end else begin
                        gen_cnt_q <= gen_cnt_q + 1'b1;
                    end
                end
                G_STORE: begin
                    gen_cnt_q <= gen_cnt_q + 1'b1;
                    if (gen_cnt_q == STORE_LAST) begin
                        gen_state_q <= G_DONE;
                        dmrs_ready_o <= 1'b1;
                    end
                end
                default: begin
                    if (id_accept) begin
                        gen_state_q <= G_LOAD;
                        offset_q <= n_id_i[OFS_W-1:0];
                        dmrs_ready_o <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_state_q <= D_IDLE;
            sc_cnt_q <= '0;
            pilot_cnt_q <= '0;
        end else if (id_accept && det_state_q == D_SYMBOL) begin
            // the stored sequences are about to change, drop the symbol
            det_state_q <= D_IDLE;
        end else begin
            if (det_state_q == D_DECIDE) begin
                det_state_q <= D_IDLE;
            end else if (start_ok) begin
                det_state_q <= D_SYMBOL;
                sc_cnt_q <= '0;
                pilot_cnt_q <= '0;
            end
            if (sample_take) begin
                sc_cnt_q <= sc_cur + 1'b1;
                pilot_cnt_q <= is_pilot ? pilot_cur + 1'b1 : pilot_cur;
                if (sc_cur == SC_LAST) begin
                    det_state_q <= D_DECIDE;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/pbch_ibar_detector.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module pbch_ibar_detector import pbch_pkg::*; (
    input  wire             clk_i,
    input  wire             reset_ni,
    input  wire cell_id_t   n_id_i,
    input  wire             n_id_valid_i,
    input  wire iq_sample_t sample_i,
    input  wire             sample_valid_i,
    input  wire             pbch_start_i,
    output logic            dmrs_ready_o,
    output ibar_t           ibar_o,
    output corr_mag_t       corr_peak_o,
    output logic            ibar_valid_o
);

    logic                      gold_load;
    logic                      gold_step;
    logic [`PBCH_NUM_IBAR-1:0] gold_bits;
    logic                      store_we;
    dmrs_idx_t                 store_idx;
    logic                      store_phase;
    pilot_strobe_t             pilot;
    logic                      corr_clear;
    logic                      corr_decide;
    dmrs_row_t                 dmrs_row;

    pbch_dmrs_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .gold_load_o    (gold_load),
        .gold_step_o    (gold_step),
        .store_we_o     (store_we),
        .store_idx_o    (store_idx),
        .store_phase_o  (store_phase),
        .pilot_o        (pilot),
        .corr_clear_o   (corr_clear),
        .corr_decide_o  (corr_decide),
        .dmrs_ready_o   (dmrs_ready_o)
    );

    gold_seq_gen u_gold (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .n_id_i      (n_id_i),
        .load_i      (gold_load),
        .step_i      (gold_step),
        .gold_bits_o (gold_bits)
    );

    dmrs_store u_store (
        .clk_i       (clk_i),
        .we_i        (store_we),
        .idx_i       (store_idx),
        .phase_i     (store_phase),
        .gold_bits_i (gold_bits),
        .rd_idx_i    (pilot.idx),
        .row_o       (dmrs_row)
    );

    dmrs_correlator u_corr (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .pilot_i      (pilot),
        .row_i        (dmrs_row),
        .clear_i      (corr_clear),
        .decide_i     (corr_decide),
        .ibar_o       (ibar_o),
        .corr_peak_o  (corr_peak_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

`default_nettype wire

/* bench/pbch_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module pbch_checker import pbch_pkg::*; (
    input  wire            clk_i,
    input  wire            reset_ni,
    input  wire            n_id_valid_i,
    input  wire            dmrs_ready_i,
    input  wire ibar_t     ibar_i,
    input  wire corr_mag_t corr_peak_i,
    input  wire            ibar_valid_i,
    input  wire            exp_strobe_i,
    input  wire ibar_t     exp_ibar_i,
    input  wire corr_mag_t exp_peak_i,
    output int             errors_o,
    output int             checks_o
);

    // dmrs_ready_o is due 1890 cycles after the load cycle
    localparam int READY_EDGES = 1890;
    // the result is registered 2 cycles after the last sample and seen one edge later
    localparam int RESULT_EDGES = 3;

    int        ready_age;
    int        result_age;
    bit        in_reset;
    ibar_t     exp_ibar_q;
    corr_mag_t exp_peak_q;

    // unknown bits in the DUT value count as a mismatch
    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        checks_o++;
        if (got !== expected) begin
            errors_o++;
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic report(input string what);
        errors_o++;
        $display("%0t ns %s", $time, what);
    endtask

    initial begin
        errors_o = 0;
        checks_o = 0;
        ready_age = 0;
        result_age = 0;
        in_reset = 1'b0;
    end

    // all ports are read at the rising edge, so each value is the one settled before it
    always @(posedge clk_i) begin
        if (!reset_ni) begin
            in_reset <= 1'b1;
            ready_age <= 0;
            result_age <= 0;
        end else begin
            if (in_reset) begin
                compare("dmrs_ready_o", dmrs_ready_i, 0);
                compare("ibar_valid_o", ibar_valid_i, 0);
                compare("ibar_o", ibar_i, 0);
                compare("corr_peak_o", corr_peak_i, 0);
                in_reset <= 1'b0;
            end

            if (n_id_valid_i) begin
                ready_age <= 1;
            end else if (ready_age != 0) begin
                if (dmrs_ready_i) begin
                    compare("dmrs_ready_o rise delay", ready_age, READY_EDGES);
                    ready_age <= 0;
                end else if (ready_age == READY_EDGES) begin
                    report("dmrs_ready_o did not rise in time after a cell ID load");
                    ready_age <= 0;
                end else begin
                    ready_age <= ready_age + 1;
                end
            end

            if (exp_strobe_i) begin
                result_age <= 1;
                exp_ibar_q <= exp_ibar_i;
                exp_peak_q <= exp_peak_i;
            end else if (result_age == RESULT_EDGES) begin
                result_age <= 0;
            end else if (result_age != 0) begin
                result_age <= result_age + 1;
            end

            if (ibar_valid_i) begin
                if (result_age == RESULT_EDGES) begin
                    compare("ibar_o", ibar_i, exp_ibar_q);
                    compare("corr_peak_o", corr_peak_i, exp_peak_q);
                end else begin
                    report("ibar_valid_o pulsed when no result was due");
                end
            end else if (result_age == RESULT_EDGES) begin
                report("ibar_valid_o missing 2 cycles after the last sample");
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_pbch_ibar.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pbch_settings.svh"

module tb_pbch_ibar import pbch_pkg::*; ();

    localparam int NUM_TESTS = 19;
    localparam int FFT_LEN = `PBCH_FFT_LEN;
    localparam int SPACING = `PBCH_PILOT_SPACING;
    localparam int NUM_PILOTS = FFT_LEN / SPACING;
    localparam int X_LEN = `PBCH_GOLD_NC + 2 * `PBCH_DMRS_LEN + `PBCH_LFSR_N;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (1890 + 400) + 2000;
    localparam bit [31:0] SEED = 32'habdcb460;

    typedef struct packed {
        cell_id_t   cell_id;
        ibar_t      ibar;
        logic       rotate;
        logic [3:0] flips;
        logic [7:0] gaps;
    } test_row_t;

    // cell ID, sent i-bar, rotate by 90 degrees, flipped pilot bits, valid-low cycles
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{10'd101, 3'd0, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd1, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd2, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd3, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd4, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd5, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd6, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd7, 1'b0, 4'd0, 8'd0},
        '{10'd101, 3'd3, 1'b1, 4'd0, 8'd0},
        '{10'd101, 3'd5, 1'b0, 4'd8, 8'd0},
        '{10'd101, 3'd6, 1'b1, 4'd5, 8'd0},
        '{10'd101, 3'd2, 1'b0, 4'd0, 8'd40},
        '{10'd101, 3'd7, 1'b1, 4'd3, 8'd90},
        '{10'd1007, 3'd4, 1'b0, 4'd0, 8'd0},
        '{10'd1007, 3'd1, 1'b0, 4'd2, 8'd25},
        '{10'd2, 3'd0, 1'b1, 4'd0, 8'd0},
        '{10'd2, 3'd6, 1'b1, 4'd8, 8'd60},
        '{10'd512, 3'd1, 1'b0, 4'd0, 8'd10},
        '{10'd512, 3'd7, 1'b1, 4'd4, 8'd0}
    };

    logic       clk;
    logic       reset_ni;
    cell_id_t   n_id;
    logic       n_id_valid;
    iq_sample_t sample;
    logic       sample_valid;
    logic       pbch_start;
    logic       dmrs_ready;
    ibar_t      ibar;
    corr_mag_t  corr_peak;
    logic       ibar_valid;
    logic       exp_strobe;
    ibar_t      exp_ibar;
    corr_mag_t  exp_peak;
    int         errors;
    int         checks;
    int         cycle_cnt = 0;
    int         current_cell;

    dmrs_pair_t ref_pairs [`PBCH_NUM_IBAR][`PBCH_DMRS_LEN];
    dmrs_pair_t rx_pairs [NUM_PILOTS];
    iq_sample_t symbol [FFT_LEN];
    int         gap_before [FFT_LEN];
    bit         x1 [X_LEN];
    bit         x2 [X_LEN];

    pbch_ibar_detector u_dut (
        .clk_i          (clk),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id),
        .n_id_valid_i   (n_id_valid),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .pbch_start_i   (pbch_start),
        .dmrs_ready_o   (dmrs_ready),
        .ibar_o         (ibar),
        .corr_peak_o    (corr_peak),
        .ibar_valid_o   (ibar_valid)
    );

    pbch_checker u_check (
        .clk_i        (clk),
        .reset_ni     (reset_ni),
        .n_id_valid_i (n_id_valid),
        .dmrs_ready_i (dmrs_ready),
        .ibar_i       (ibar),
        .corr_peak_i  (corr_peak),
        .ibar_valid_i (ibar_valid),
        .exp_strobe_i (exp_strobe),
        .exp_ibar_i   (exp_ibar),
        .exp_peak_i   (exp_peak),
        .errors_o     (errors),
        .checks_o     (checks)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with the test sequence unfinished", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // +1 for each matching bit of the pair and -1 for each differing bit
    function automatic int pair_match(input dmrs_pair_t a, input dmrs_pair_t b);
        return (a[1] == b[1] ? 1 : -1) + (a[0] == b[0] ? 1 : -1);
    endfunction

    function automatic int magnitude(input int value);
        return (value < 0) ? -value : value;
    endfunction

    // a set sign bit means a negative component
    function automatic logic signed [`PBCH_IQ_W-1:0] rand_level(input bit negative);
        logic signed [`PBCH_IQ_W-1:0] level;
        level = 256 + $urandom_range(0, 16000);
        return negative ? -level : level;
    endfunction

    // Gold sequences per TS 38.211, c(n) = x1(n + Nc) ^ x2(n + Nc)
    task automatic build_sequences(input int cell_id);
        logic [30:0] c_init;
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            c_init = (i + 1) * (cell_id / 4 + 1) * 2048 + (i + 1) * 64 + cell_id % 4;
            for (int n = 0; n < `PBCH_LFSR_N; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (int n = `PBCH_LFSR_N; n < X_LEN; n++) begin
                x1[n] = x1[n-28] ^ x1[n-31];
                x2[n] = x2[n-28] ^ x2[n-29] ^ x2[n-30] ^ x2[n-31];
            end
            for (int m = 0; m < `PBCH_DMRS_LEN; m++) begin
                ref_pairs[i][m] = {x1[`PBCH_GOLD_NC + 2*m] ^ x2[`PBCH_GOLD_NC + 2*m],
                                   x1[`PBCH_GOLD_NC + 2*m + 1] ^ x2[`PBCH_GOLD_NC + 2*m + 1]};
            end
        end
    endtask

    // builds the received symbol and the expected decision for one table row
    task automatic prepare_symbol(input test_row_t row);
        dmrs_pair_t tx;
        dmrs_pair_t rot;
        bit         flipped [NUM_PILOTS];
        bit         which;
        int         pick;
        int         pilot;
        int         acc;
        int         acc_rot;
        int         mag;
        int         best_mag;
        ibar_t      best;
        for (int k = 0; k < NUM_PILOTS; k++) begin
            tx = ref_pairs[row.ibar][k];
            // multiplying by j moves the negated im sign to re and the re sign to im
            rx_pairs[k] = row.rotate ? {~tx[0], tx[1]} : tx;
            flipped[k] = 1'b0;
        end
        for (int f = 0; f < int'(row.flips); f++) begin
            do begin
                pick = $urandom_range(0, NUM_PILOTS - 1);
            end while (flipped[pick]);
            flipped[pick] = 1'b1;
            which = $urandom_range(0, 1);
            rx_pairs[pick][which] = ~rx_pairs[pick][which];
        end
        pilot = 0;
        for (int c = 0; c < FFT_LEN; c++) begin
            if (c % SPACING == int'(row.cell_id) % SPACING) begin
                symbol[c].re = rand_level(rx_pairs[pilot][1]);
                symbol[c].im = rand_level(rx_pairs[pilot][0]);
                pilot++;
            end else begin
                symbol[c].re = rand_level($urandom_range(0, 1));
                symbol[c].im = rand_level($urandom_range(0, 1));
            end
            gap_before[c] = 0;
        end
        for (int g = 0; g < int'(row.gaps); g++) begin
            pick = $urandom_range(1, FFT_LEN - 1);
            gap_before[pick]++;
        end
        best = '0;
        best_mag = -1;
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            acc = 0;
            acc_rot = 0;
            for (int k = 0; k < NUM_PILOTS; k++) begin
                rot = {~rx_pairs[k][0], rx_pairs[k][1]};
                acc += pair_match(ref_pairs[i][k], rx_pairs[k]);
                acc_rot += pair_match(ref_pairs[i][k], rot);
            end
            mag = (magnitude(acc_rot) > magnitude(acc)) ? magnitude(acc_rot) : magnitude(acc);
            if (mag > best_mag) begin
                best_mag = mag;
                best = ibar_t'(i);
            end
        end
        exp_ibar <= best;
        exp_peak <= corr_mag_t'(best_mag);
    endtask

    task automatic send_symbol(input bit expect_result);
        for (int s = 0; s < FFT_LEN; s++) begin
            for (int g = 0; g < gap_before[s]; g++) begin
                @(posedge clk);
                sample <= iq_sample_t'($urandom);
                sample_valid <= 1'b0;
                pbch_start <= 1'b0;
            end
            @(posedge clk);
            sample <= symbol[s];
            sample_valid <= 1'b1;
            pbch_start <= (s == 0);
            exp_strobe <= expect_result && (s == FFT_LEN - 1);
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        pbch_start <= 1'b0;
        exp_strobe <= 1'b0;
    endtask

    task automatic load_cell(input int cell_id);
        test_row_t early;
        @(posedge clk);
        n_id <= cell_id_t'(cell_id);
        n_id_valid <= 1'b1;
        @(posedge clk);
        n_id_valid <= 1'b0;
        build_sequences(cell_id);
        repeat (4) @(posedge clk);
        // a symbol that starts while the sequences are being built must be ignored
        early.cell_id = cell_id_t'(cell_id);
        early.ibar = '0;
        early.rotate = 1'b0;
        early.flips = '0;
        early.gaps = '0;
        prepare_symbol(early);
        send_symbol(1'b0);
        while (!dmrs_ready) @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        reset_ni = 1'b0;
        n_id = '0;
        n_id_valid = 1'b0;
        sample = '0;
        sample_valid = 1'b0;
        pbch_start = 1'b0;
        exp_strobe = 1'b0;
        exp_ibar = '0;
        exp_peak = '0;
        current_cell = -1;
        repeat (2) @(posedge clk);
        reset_ni <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (int'(TESTS[t].cell_id) != current_cell) begin
                current_cell = int'(TESTS[t].cell_id);
                load_cell(current_cell);
            end
            prepare_symbol(TESTS[t]);
            send_symbol(1'b1);
            while (!ibar_valid) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
src/pbch_pkg.sv
src/gold_seq_gen.sv
src/dmrs_store.sv
src/dmrs_correlator.sv
src/pbch_dmrs_ctrl.sv
src/pbch_ibar_detector.sv
bench/pbch_checker.sv
bench/tb_pbch_ibar.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps -Wno-fatal
TOP      := tb_pbch_ibar
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log
SOURCES  := $(wildcard src/*.sv bench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
